/* Makefile */
TOOL      := verilator
FLAGS     := --binary --timing --assert
TOP       := crc24_tb
FILELIST  := flist.f
OBJ_DIR   := obj_dir
PASS_TEXT := NO ERRORS

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

# the run passes only if the pass message shows up as a line of its own
test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

/* bench/crc24_ref.svh */
`ifndef crc24_ref_svh
`define crc24_ref_svh

// interlaken crc24 straight from its definition, one bit per step
// state and data both go msb first, nothing is reflected or inverted
localparam logic [23:0] ref_poly = 24'h32_8b63;
localparam logic [23:0] ref_init = 24'hff_ffff;
localparam int ref_word_bits = 64;

// classic 32 bit xorshift with shifts 13, 17 and 5
function automatic logic [31:0] xorshift32(logic [31:0] s);
	logic [31:0] x;
	x = s;
	x = x ^ (x << 13);
	x = x ^ (x >> 17);
	x = x ^ (x << 5);
	return x;
endfunction

// word 0 is the first word on the wire, only n_words of the array count
task automatic crc_serial(
	input  logic [ref_word_bits-1:0] words [3],
	input  int                       n_words,
	output logic [23:0]              crc_val
);
	logic [23:0] c;
	logic fb;
	c = ref_init;
	for (int w = 0; w < n_words; w++) begin
		for (int b = ref_word_bits - 1; b >= 0; b--) begin
			fb = c[23] ^ words[w][b];
			c = {c[22:0], 1'b0};
			if (fb) begin
				c = c ^ ref_poly;
			end
		end
	end
	crc_val = c;
endtask

`endif

/* bench/crc24_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module crc24_tb;

	import crc24_pkg::*;
	import burst_pkg::*;

	localparam int clk_period = 8;
	// message counts per test, the watchdog budget is taken from them
	localparam int n_single = 16;
	localparam int n_two    = 16;
	localparam int n_three  = 16;
	localparam int n_mixed  = 48;
	localparam int n_stall  = 32;
	// random lengths are budgeted at three words each
	localparam int max_words = n_single + 2 * n_two + 3 * n_three + 3 * (n_mixed + n_stall);
	localparam int watchdog_cycles = 40 * max_words + 200;
	// idle cycles a test waits for its last results before moving on
	localparam int drain_cycles = 8;

	logic       clk;
	logic       arst;
	logic       ena;
	word_beat_t beat;
	crc_t       crc;
	logic       crc_done;

	// one xorshift state feeds data, lengths, gaps and stalls
	logic [31:0] rng;
	// expected crcs in send order, and the enabled edge at which each one is due
	logic [23:0] exp_q[$];
	int          due_q[$];
	int          en_count;
	bit          edge_enabled;
	bit          running;
	logic [23:0] last_crc;
	logic        last_done;
	string       test_name;
	int          checks;
	int          errors;
	int          tests;

	`include "crc24_ref.svh"

	crc24_top #(.word_bits(word_width)) uut (
		.clk     (clk),
		.arst    (arst),
		.ena     (ena),
		.beat    (beat),
		.crc     (crc),
		.crc_done(crc_done)
	);

	initial begin
		clk = 1'b0;
		forever #(clk_period / 2) clk = ~clk;
	end

	//////////////////////////////////////////////////
	// error reporting
	//////////////////////////////////////////////////

	task automatic report_mismatch(string what, logic [23:0] expected, logic [23:0] actual);
		errors++;
		$display("** Error %s: %s expected %06h actual %06h", test_name, what, expected, actual);
	endtask

	task automatic report_flag(string what, logic expected, logic actual);
		errors++;
		$display("** Error %s: %s expected %b actual %b", test_name, what, expected, actual);
	endtask

	task automatic report_fault(string msg);
		errors++;
		$display("%s: %s", test_name, msg);
	endtask

	//////////////////////////////////////////////////
	// result checking
	//////////////////////////////////////////////////

	// inputs are read here before the driver's updates land, just as the DUT sees them
	// the edge that takes in a last beat is enabled edge k, the crc shows up after k+2
	always @(posedge clk) begin
		if (running && ena) begin
			en_count++;
			if (beat.valid && beat.last) begin
				due_q.push_back(en_count + 2);
			end
		end
		edge_enabled = ena;
	end

	// outputs are settled at the falling edge
	always @(negedge clk) begin
		if (running) begin
			if (!edge_enabled) begin
				// a stalled edge must leave both outputs exactly as they were
				checks++;
				assert (crc === last_crc && crc_done === last_done) else
					report_fault("crc or crc_done changed on an edge with ena low");
			end else begin
				// crc_done has to show up on exactly the enabled edge that is due
				checks++;
				if (due_q.size() != 0 && due_q[0] == en_count) begin
					assert (crc_done === 1'b1) else report_flag("crc_done", 1'b1, crc_done);
					void'(due_q.pop_front());
				end else begin
					assert (crc_done === 1'b0) else report_flag("crc_done", 1'b0, crc_done);
				end
				// every crc_done retires the oldest expected crc
				if (crc_done === 1'b1) begin
					checks += 2;
					assert (exp_q.size() != 0) else
						report_fault("crc_done rose with no message outstanding");
					if (exp_q.size() != 0) begin
						assert (crc === exp_q[0]) else report_mismatch("crc", exp_q[0], crc);
						void'(exp_q.pop_front());
					end
				end
			end
			last_crc = crc;
			last_done = crc_done;
		end
	end

	//////////////////////////////////////////////////
	// stimulus
	//////////////////////////////////////////////////

	task automatic idle_cycle();
		@(posedge clk);
		ena <= 1'b1;
		beat <= '0;
	endtask

	// stalled cycles carry junk beats, which the DUT has to ignore
	task automatic drive_word(logic [63:0] data, logic is_first, logic is_last, bit stalls);
		word_beat_t b;
		int n_stall;
		n_stall = 0;
		if (stalls) begin
			rng = xorshift32(rng);
			n_stall = int'(rng % 32'd4);
		end
		repeat (n_stall) begin
			@(posedge clk);
			rng = xorshift32(rng);
			b.data  = {rng, ~rng};
			b.valid = rng[0];
			b.first = rng[1];
			b.last  = rng[2];
			ena  <= 1'b0;
			beat <= b;
		end
		@(posedge clk);
		b.data  = data;
		b.valid = 1'b1;
		b.first = is_first;
		b.last  = is_last;
		ena  <= 1'b1;
		beat <= b;
	endtask

	// fixed_len of zero picks a random length of one to three words per message
	task automatic run_test(string name, int n_msgs, int fixed_len, bit stalls);
		logic [ref_word_bits-1:0] words [3];
		logic [23:0] expected;
		int n_words;
		int gap;
		int drain;
		int checks_at_start;
		int errors_at_start;
		test_name = name;
		checks_at_start = checks;
		errors_at_start = errors;
		for (int m = 0; m < n_msgs; m++) begin
			rng = xorshift32(rng);
			n_words = (fixed_len != 0) ? fixed_len : int'(rng % 32'd3) + 1;
			for (int w = 0; w < 3; w++) begin
				rng = xorshift32(rng);
				words[w][63:32] = rng;
				rng = xorshift32(rng);
				words[w][31:0] = rng;
			end
			crc_serial(words, n_words, expected);
			exp_q.push_back(expected);
			for (int w = 0; w < n_words; w++) begin
				drive_word(words[w], w == 0, w == n_words - 1, stalls);
			end
			// fixed length runs leave short idle gaps, random runs go back to back
			if (fixed_len != 0) begin
				rng = xorshift32(rng);
				gap = int'(rng % 32'd3);
				repeat (gap) idle_cycle();
			end
		end
		idle_cycle();
		// results still missing after the drain window are left for the final check
		drain = 0;
		while (exp_q.size() != 0 && drain < drain_cycles) begin
			idle_cycle();
			drain++;
		end
		tests++;
		$display("test %-18s %0d messages, %0d checks, %0d errors", name, n_msgs,
			checks - checks_at_start, errors - errors_at_start);
	endtask

	task automatic check_reset_state();
		test_name = "reset_state";
		checks += 2;
		assert (crc === ref_init) else report_mismatch("crc", ref_init, crc);
		assert (crc_done === 1'b0) else report_flag("crc_done", 1'b0, crc_done);
		tests++;
		$display("test %-18s 2 checks, %0d errors", test_name, errors);
	endtask

	//////////////////////////////////////////////////
	// test sequence and watchdog
	//////////////////////////////////////////////////

	initial begin
		arst = 1'b1;
		ena = 1'b0;
		beat = '0;
		rng = 32'hdf1d_1404;
		en_count = 0;
		edge_enabled = 1'b0;
		running = 1'b0;
		last_crc = '0;
		last_done = 1'b0;
		test_name = "reset";
		checks = 0;
		errors = 0;
		tests = 0;
		repeat (3) @(posedge clk);
		arst <= 1'b0;
		ena <= 1'b1;
		// the outputs already hold their reset values, watching starts on this edge
		last_crc = crc;
		last_done = crc_done;
		running = 1'b1;
		@(negedge clk);
		check_reset_state();
		run_test("single_word", n_single, 1, 1'b0);
		run_test("two_words", n_two, 2, 1'b0);
		run_test("three_words", n_three, 3, 1'b0);
		run_test("back_to_back_mixed", n_mixed, 0, 1'b0);
		run_test("ena_stalls", n_stall, 0, 1'b1);
		test_name = "end_of_run";
		checks++;
		assert (exp_q.size() == 0 && due_q.size() == 0) else
			report_fault("results still outstanding at the end of the run");
		$display("summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
		if (errors == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

	// forty cycles per word covers the latency, idle gaps and the longest stalls
	initial begin
		#(watchdog_cycles * clk_period);
		$display("watchdog: run did not finish within %0d clock cycles", watchdog_cycles);
		$display("ERRORS FOUND");
		$finish;
	end

endmodule

`default_nettype wire

/* design/burst_pkg.sv */
`default_nettype none

package burst_pkg;

	import crc24_pkg::*;

	// width of one data word on the input
	localparam int word_width = 64;

	//////////////////////////////////////////////////
	// input beat
	//////////////////////////////////////////////////

	// first and last mark the message boundaries, a one word message has both set
	typedef struct packed {
		logic [word_width-1:0] data;
		logic                  valid;
		logic                  first;
		logic                  last;
	} word_beat_t;

	//////////////////////////////////////////////////
	// history to combiner
	//////////////////////////////////////////////////

	// cur is the partial of the closing word, prev1 the word before it
	// prev2 is the oldest word and already carries the seeded init term
	typedef struct packed {
		crc_t  cur;
		crc_t  prev1;
		crc_t  prev2;
		span_e span;
		logic  done;
	} span_slots_t;

endpackage

`default_nettype wire

/* design/crc24_pkg.sv */
`default_nettype none

package crc24_pkg;

	//////////////////////////////////////////////////
	// interlaken crc24 constants
	//////////////////////////////////////////////////

	// the state is shifted msb first with no bit reflection
	localparam int crc_width = 24;

	typedef logic [crc_width-1:0] crc_t;

	// generator x^24 + x^21 + x^20 + x^17 + x^15 + x^11 + x^9 + x^8 + x^6 + x^5 + x + 1
	localparam crc_t crc_poly = 24'h32_8b63;

	// a message starts from all ones and the result is not inverted at the end
	localparam crc_t crc_init = {crc_width{1'b1}};

	//////////////////////////////////////////////////
	// span of a closing word
	//////////////////////////////////////////////////

	// how many earlier words of the same message the current word has to absorb
	typedef enum logic [1:0] {
		span_none = 2'd0,
		span_one  = 2'd1,
		span_two  = 2'd2
	} span_e;

	// one serial step of the lfsr, used only at elaboration to build the xor tables
	function automatic crc_t crc_step(crc_t c, logic din);
		logic fb;
		fb = c[crc_width-1] ^ din;
		return {c[crc_width-2:0], 1'b0} ^ (fb ? crc_poly : crc_t'(0));
	endfunction

endpackage

`default_nettype wire

/* design/crc24_span_combine.sv */
`timescale 1ns/1ns
`default_nettype none

module crc24_span_combine #(
	parameter int word_bits = 64
) (
	input  wire logic                   clk,
	input  wire logic                   arst,
	input  wire logic                   ena,
	input  wire burst_pkg::span_slots_t slots,
	output crc24_pkg::crc_t             crc,
	output logic                        crc_done
);

	import crc24_pkg::*;

	// init advanced across one, two and three words, all constants
	crc_t init_adv1;
	crc_t init_adv2;
	crc_t init_adv3;
	// older partials advanced up to the closing word
	crc_t prev1_adv;
	crc_t prev2_adv;

	span_e span_r;
	crc_t base_term;
	logic use_prev1;
	crc_t prev1_term;
	crc_t cur_r;
	logic last_done;

	//////////////////////////////////////////////////
	// constant init terms
	//////////////////////////////////////////////////

	crc24_zero_advance #(.word_bits(word_bits), .zero_words(1)) u_init1 (
		.c      (crc_init),
		.crc_out(init_adv1)
	);

	crc24_zero_advance #(.word_bits(word_bits), .zero_words(2)) u_init2 (
		.c      (crc_init),
		.crc_out(init_adv2)
	);

	crc24_zero_advance #(.word_bits(word_bits), .zero_words(3)) u_init3 (
		.c      (crc_init),
		.crc_out(init_adv3)
	);

	//////////////////////////////////////////////////
	// older partials
	//////////////////////////////////////////////////

	crc24_zero_advance #(.word_bits(word_bits), .zero_words(1)) u_prev1 (
		.c      (slots.prev1),
		.crc_out(prev1_adv)
	);

	// prev2 is read one cycle after the closing beat, the history does not
	// move it on a last word so it is still valid here
	crc24_zero_advance #(.word_bits(word_bits), .zero_words(2)) u_prev2 (
		.c      (slots.prev2),
		.crc_out(prev2_adv)
	);

	// the span is registered first and the base term is picked after it
	always_ff @(posedge clk or posedge arst) begin
		if (arst) begin
			span_r <= span_none;
		end else if (ena) begin
			span_r <= slots.span;
		end
	end

	// for three words the seeded prev2 already carries the init term
	// an encoding outside the enum falls back to the plain three word init
	always_comb begin
		case (span_r)
			span_none: base_term = init_adv1;
			span_one:  base_term = init_adv2;
			span_two:  base_term = prev2_adv;
			default:   base_term = init_adv3;
		endcase
	end

	// prev1 only counts when the closing word has at least one word before it
	assign use_prev1 = (slots.span == span_one) || (slots.span == span_two);

	always_ff @(posedge clk or posedge arst) begin
		if (arst) begin
			prev1_term <= '0;
		end else if (ena) begin
			prev1_term <= use_prev1 ? prev1_adv : '0;
		end
	end

	// the closing word's own partial is always in, delayed to line up
	always_ff @(posedge clk or posedge arst) begin
		if (arst) begin
			cur_r     <= '0;
			last_done <= 1'b0;
		end else if (ena) begin
			cur_r     <= slots.cur;
			last_done <= slots.done;
		end
	end

	//////////////////////////////////////////////////
	// message crc
	//////////////////////////////////////////////////

	// crc_done rises together with the new value and falls on the next enabled edge
	always_ff @(posedge clk or posedge arst) begin
		if (arst) begin
			crc      <= crc_init;
			crc_done <= 1'b0;
		end else if (ena) begin
			crc_done <= last_done;
			if (last_done) begin
				crc <= cur_r ^ base_term ^ prev1_term;
			end
		end
	end

endmodule

`default_nettype wire

/* design/crc24_span_history.sv */
`timescale 1ns/1ns
`default_nettype none

module crc24_span_history #(
	parameter int word_bits = 64
) (
	input  wire logic           clk,
	input  wire logic           arst,
	input  wire logic           ena,
	input  wire crc24_pkg::crc_t part,
	input  wire logic           part_valid,
	input  wire logic           part_first,
	input  wire logic           part_last,
	output burst_pkg::span_slots_t slots
);

	import crc24_pkg::*;

	// init advanced by one word, added to the first word when it lands in prev2
	crc_t seed;
	crc_t prev1_q;
	crc_t prev2_q;
	// words of the current message already held, saturates at two
	logic [1:0] count;
	span_e span;

	crc24_zero_advance #(
		.word_bits (word_bits),
		.zero_words(1)
	) u_seed (
		.c      (crc_init),
		.crc_out(seed)
	);

	//////////////////////////////////////////////////
	// span of the word in the pipeline
	//////////////////////////////////////////////////

	// a first word never looks back, even if the last message was cut short
	always_comb begin
		if (part_first) begin
			span = span_none;
		end else begin
			case (count)
				2'd0:    span = span_none;
				2'd1:    span = span_one;
				default: span = span_two;
			endcase
		end
	end

	//////////////////////////////////////////////////
	// partial history
	//////////////////////////////////////////////////

	// only words that do not close the message are pushed back
	// the closing word leaves the slots alone so the combiner can still read
	// prev2 one cycle later
	always_ff @(posedge clk or posedge arst) begin
		if (arst) begin
			count   <= 2'd0;
			prev1_q <= '0;
			prev2_q <= '0;
		end else if (ena && part_valid) begin
			if (part_last) begin
				count <= 2'd0;
			end else begin
				prev1_q <= part;
				if (part_first) begin
					count   <= 2'd1;
					prev2_q <= '0;
				end else begin
					// prev1 holds the first word when count is one, so seed it now
					prev2_q <= (count == 2'd1) ? (prev1_q ^ seed) : prev1_q;
					if (count != 2'd2) begin
						count <= count + 2'd1;
					end
				end
			end
		end
	end

	// slots follow the word stage directly; done marks the closing beat
	always_comb begin
		slots.cur   = part;
		slots.prev1 = prev1_q;
		slots.prev2 = prev2_q;
		slots.span  = span;
		slots.done  = part_valid & part_last;
	end

endmodule

`default_nettype wire

/* design/crc24_top.sv */
`timescale 1ns/1ns
`default_nettype none

module crc24_top #(
	parameter int word_bits = burst_pkg::word_width
) (
	input  wire logic                  clk,
	input  wire logic                  arst,
	input  wire logic                  ena,
	input  wire burst_pkg::word_beat_t beat,
	output crc24_pkg::crc_t            crc,
	output logic                       crc_done
);

	import crc24_pkg::*;
	import burst_pkg::*;

	// per word partial and its flags, one enabled cycle behind the beat
	crc_t part;
	logic part_valid;
	logic part_first;
	logic part_last;
	// lined up partials of the message being closed
	span_slots_t slots;

	//////////////////////////////////////////////////
	// pipeline word crc, history, combiner
	//////////////////////////////////////////////////

	crc24_word #(.word_bits(word_bits)) u_word (
		.clk       (clk),
		.arst      (arst),
		.ena       (ena),
		.beat      (beat),
		.part      (part),
		.part_valid(part_valid),
		.part_first(part_first),
		.part_last (part_last)
	);

	crc24_span_history #(.word_bits(word_bits)) u_history (
		.clk       (clk),
		.arst      (arst),
		.ena       (ena),
		.part      (part),
		.part_valid(part_valid),
		.part_first(part_first),
		.part_last (part_last),
		.slots     (slots)
	);

	// two more register levels, crc lands three enabled edges after the beat
	crc24_span_combine #(.word_bits(word_bits)) u_combine (
		.clk     (clk),
		.arst    (arst),
		.ena     (ena),
		.slots   (slots),
		.crc     (crc),
		.crc_done(crc_done)
	);

endmodule

`default_nettype wire

/* design/crc24_word.sv */
`timescale 1ns/1ns
`default_nettype none

module crc24_word #(
	parameter int word_bits = 64
) (
	input  wire logic                  clk,
	input  wire logic                  arst,
	input  wire logic                  ena,
	input  wire burst_pkg::word_beat_t beat,
	output crc24_pkg::crc_t            part,
	output logic                       part_valid,
	output logic                       part_first,
	output logic                       part_last
);

	import crc24_pkg::*;

	// the word must fit in the beat, the low word_bits bits are used
	logic [word_bits-1:0] data_w;
	crc_t part_next;

	// bit out_bit of the zero-initialised crc is the parity of the data bits
	// whose single-bit word would set that bit, so build the tap mask here
	function automatic logic [word_bits-1:0] data_taps(int out_bit);
		logic [word_bits-1:0] taps;
		crc_t c;
		taps = '0;
		for (int i = 0; i < word_bits; i++) begin
			c = '0;
			// data goes out msb first, so bit word_bits-1 enters the lfsr first
			for (int k = word_bits - 1; k >= 0; k--) begin
				c = crc_step(c, k == i);
			end
			taps[i] = c[out_bit];
		end
		return taps;
	endfunction

	assign data_w = beat.data[word_bits-1:0];

	//////////////////////////////////////////////////
	// flat xor network, one parity tree per crc bit
	//////////////////////////////////////////////////

	for (genvar j = 0; j < crc_width; j++) begin : g_bit
		localparam logic [word_bits-1:0] taps = data_taps(j);
		assign part_next[j] = ^(data_w & taps);
	end

	//////////////////////////////////////////////////
	// output registers
	//////////////////////////////////////////////////

	// partial and flags move together, one enabled cycle behind the beat
	always_ff @(posedge clk or posedge arst) begin
		if (arst) begin
			part       <= '0;
			part_valid <= 1'b0;
			part_first <= 1'b0;
			part_last  <= 1'b0;
		end else if (ena) begin
			part       <= part_next;
			part_valid <= beat.valid;
			part_first <= beat.first;
			part_last  <= beat.last;
		end
	end

endmodule

`default_nettype wire

/* design/crc24_zero_advance.sv */
`timescale 1ns/1ns
`default_nettype none

module crc24_zero_advance #(
	parameter int word_bits  = 64,
	parameter int zero_words = 1
) (
	input  wire crc24_pkg::crc_t c,
	output crc24_pkg::crc_t      crc_out
);

	import crc24_pkg::*;

	// total number of zero bits that the state is pushed across
	localparam int zero_bits = zero_words * word_bits;

	// shifting in zeros is linear in the state, so each output bit is the parity
	// of a fixed set of input bits, found by running every unit state through
	function automatic crc_t state_taps(int out_bit);
		crc_t taps;
		crc_t s;
		taps = '0;
		for (int i = 0; i < crc_width; i++) begin
			s = crc_t'(1) << i;
			for (int k = 0; k < zero_bits; k++) begin
				s = crc_step(s, 1'b0);
			end
			taps[i] = s[out_bit];
		end
		return taps;
	endfunction

	//////////////////////////////////////////////////
	// constant matrix times state
	//////////////////////////////////////////////////

	// with a constant c the whole block folds down to a constant
	for (genvar j = 0; j < crc_width; j++) begin : g_bit
		localparam crc_t taps = state_taps(j);
		assign crc_out[j] = ^(c & taps);
	end

endmodule

`default_nettype wire

/* flist.f */
+incdir+bench
design/crc24_pkg.sv
design/burst_pkg.sv
design/crc24_word.sv
design/crc24_zero_advance.sv
design/crc24_span_history.sv
design/crc24_span_combine.sv
design/crc24_top.sv
bench/crc24_tb.sv
